// File: hdl/csi2_pkt_pkg.sv
/*
  CSI-2 packet-level types and codes shared by the rx_clk blocks
  Header bytes arrive little-endian: DI in bits 7:0, ECC in bits 31:24
*/

package csi2_pkt_pkg;

  // Byte-strobed payload word, first byte on the wire in tdata[7:0]
  typedef struct packed {
    logic [31 : 0] tdata;
    logic [3 : 0]  tstrb;
    logic          tlast;
    logic          tvalid;
  } csi2_word_t;

  // Overlays one aligned 32-bit PHY word
  typedef struct packed {
    logic [7 : 0]  ecc;
    logic [15 : 0] wc;
    logic [7 : 0]  di;
  } csi2_header_t;

  // Short packet data types
  localparam logic [5 : 0] CSI2_DT_FRAME_START = 6'h00;
  localparam logic [5 : 0] CSI2_DT_FRAME_END   = 6'h01;

  // Lowest long packet data type
  localparam logic [5 : 0] CSI2_LONG_DT_MIN    = 6'h10;

  // Payload CRC-16, reflected, LSB first
  localparam logic [15 : 0] CSI2_CRC_INIT      = 16'hFFFF;
  localparam logic [15 : 0] CSI2_CRC_POLY      = 16'h8408;

endpackage

// File: hdl/csi2_status_pkg.sv
/*
  Receiver error reporting types
  Every flag is a one-cycle pulse in the rx_clk domain
*/

package csi2_status_pkg;

  typedef struct packed {
    // Header ECC mismatch, corrected or not
    logic header_err;
    // Single-bit header error was repaired
    logic header_corr;
    // Payload CRC result
    logic crc_err;
    logic crc_ok;
  } csi2_err_t;

endpackage

// File: hdl/csi2_header_ecc.sv
/*
  Header ECC check and single-bit correction, one cycle of latency
  Only ECC bits 5:0 are checked; bits 7:6 are reserved and ignored
  The word after reset or pkt_done_i is taken as the packet header
*/

`timescale 1ns/100ps

module csi2_header_ecc
  import csi2_pkt_pkg::*;
(
  input                 rx_clk,
  input                 clk_loss_rst,
  input        [31 : 0] phy_data_i,
  input                 phy_valid_i,
  input                 pkt_done_i,
  output logic [31 : 0] data_o,
  output logic          valid_o,
  output logic          hdr_valid_o,
  output logic          hdr_err_o,
  output logic          hdr_corr_o
);

// Syndrome produced by a flip of each header data bit, as {P5..P0}
localparam logic [5 : 0] ECC_COL [24] = '{
  6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
  6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
  6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
};

csi2_header_t  hdr_in;
logic [23 : 0] hdr_bits;
logic [23 : 0] fixed_bits;
logic [5 : 0]  syndrome;
logic          data_col;
logic          ecc_col;
logic          hdr_pend;
logic          is_hdr;

assign hdr_in   = csi2_header_t'( phy_data_i );
assign hdr_bits = { hdr_in.wc, hdr_in.di };
// Resync pulse may coincide with the next header
assign is_hdr   = hdr_pend || pkt_done_i;
assign ecc_col  = $onehot( syndrome );

always_comb
  begin
    syndrome = hdr_in.ecc[5 : 0];
    for( int i = 0; i < 24; i++ )
      if( hdr_bits[i] )
        syndrome = syndrome ^ ECC_COL[i];
  end

// Flip the data bit whose column matches
always_comb
  begin
    fixed_bits = hdr_bits;
    data_col   = 1'b0;
    for( int i = 0; i < 24; i++ )
      if( syndrome == ECC_COL[i] )
        begin
          fixed_bits[i] = !hdr_bits[i];
          data_col      = 1'b1;
        end
  end

always_ff @( posedge rx_clk, posedge clk_loss_rst )
  if( clk_loss_rst )
    begin
      hdr_pend    <= 1'b1;
      valid_o     <= 1'b0;
      hdr_valid_o <= 1'b0;
      hdr_err_o   <= 1'b0;
      hdr_corr_o  <= 1'b0;
    end
  else
    begin
      if( phy_valid_i && is_hdr )
        hdr_pend <= 1'b0;
      else
        if( pkt_done_i )
          hdr_pend <= 1'b1;
      valid_o     <= phy_valid_i;
      hdr_valid_o <= phy_valid_i && is_hdr;
      hdr_err_o   <= phy_valid_i && is_hdr && ( syndrome != '0 );
      hdr_corr_o  <= phy_valid_i && is_hdr && ( data_col || ecc_col );
    end

always_ff @( posedge rx_clk )
  if( phy_valid_i )
    data_o <= is_hdr ? { hdr_in.ecc, fixed_bits } : phy_data_i;

endmodule

// File: hdl/csi2_pkt_framer.sv
/*
  Splits corrected PHY words into payload stream, CRC bytes and frame pulses
  Long packet length comes from the header word count; no back-pressure
  enable_i low drops all words and requests PHY resync every cycle
*/

`timescale 1ns/100ps

module csi2_pkt_framer
  import csi2_pkt_pkg::*;
(
  input                 rx_clk,
  input                 clk_loss_rst,
  input                 enable_i,
  input        [31 : 0] data_i,
  input                 valid_i,
  input                 hdr_valid_i,
  input                 hdr_err_i,
  input                 hdr_corr_i,
  output csi2_word_t    pkt_o,
  output logic [15 : 0] rx_crc_o,
  output logic          rx_crc_valid_o,
  output logic          frame_start_o,
  output logic          frame_end_o,
  output logic          pkt_done_o
);

csi2_header_t  hdr;
logic [5 : 0]  dt;
logic          hdr_ok;
logic          is_long;
logic          pay_word;
// Bytes left in the packet, CRC included
logic [16 : 0] rem;
logic          in_pkt;
logic [3 : 0]  strb_n;
logic          last_n;
logic [7 : 0]  crc_lo;
logic [7 : 0]  crc_lo_n;
logic [7 : 0]  crc_hi_n;
logic          crc_done_n;
logic [31 : 0] out_data;
logic [3 : 0]  out_strb;
logic          out_last;
logic          out_valid;

assign hdr      = csi2_header_t'( data_i );
assign dt       = hdr.di[5 : 0];
assign hdr_ok   = hdr_valid_i && !( hdr_err_i && !hdr_corr_i );
assign is_long  = dt >= CSI2_LONG_DT_MIN;
assign pay_word = valid_i && !hdr_valid_i && in_pkt && enable_i;
assign last_n   = ( rem > 17'd2 ) && ( rem <= 17'd6 );

// Classify each byte lane as payload, CRC low or CRC high
always_comb
  begin
    strb_n     = '0;
    crc_lo_n   = crc_lo;
    crc_hi_n   = '0;
    crc_done_n = 1'b0;
    for( int b = 0; b < 4; b++ )
      begin
        if( rem > 17'( b + 2 ) )
          strb_n[b] = 1'b1;
        if( rem == 17'( b + 2 ) )
          crc_lo_n = data_i[8 * b +: 8];
        if( rem == 17'( b + 1 ) )
          begin
            crc_hi_n   = data_i[8 * b +: 8];
            crc_done_n = 1'b1;
          end
      end
  end

always_ff @( posedge rx_clk, posedge clk_loss_rst )
  if( clk_loss_rst )
    begin
      in_pkt         <= 1'b0;
      rem            <= '0;
      out_valid      <= 1'b0;
      rx_crc_valid_o <= 1'b0;
      frame_start_o  <= 1'b0;
      frame_end_o    <= 1'b0;
      pkt_done_o     <= 1'b0;
    end
  else
    begin
      out_valid      <= pay_word && ( strb_n != '0 );
      rx_crc_valid_o <= pay_word && crc_done_n;
      frame_start_o  <= enable_i && hdr_ok && ( dt == CSI2_DT_FRAME_START );
      frame_end_o    <= enable_i && hdr_ok && ( dt == CSI2_DT_FRAME_END );
      pkt_done_o     <= !enable_i || ( hdr_valid_i && !( hdr_ok && is_long ) ) ||
                        ( pay_word && crc_done_n );
      if( !enable_i )
        in_pkt <= 1'b0;
      else
        if( hdr_valid_i )
          begin
            in_pkt <= hdr_ok && is_long;
            rem    <= { 1'b0, hdr.wc } + 17'd2;
          end
        else
          if( pay_word )
            begin
              if( rem <= 17'd4 )
                in_pkt <= 1'b0;
              else
                rem <= rem - 17'd4;
            end
    end

always_ff @( posedge rx_clk )
  if( pay_word )
    begin
      out_data <= data_i;
      out_strb <= strb_n;
      out_last <= last_n;
      crc_lo   <= crc_lo_n;
      if( crc_done_n )
        rx_crc_o <= { crc_hi_n, crc_lo_n };
    end

assign pkt_o = '{ tdata: out_data, tstrb: out_strb, tlast: out_last, tvalid: out_valid };

endmodule

// File: hdl/csi2_payload_crc.sv
/*
  Payload CRC-16 over strobed bytes, compared with the received CRC
  The running value restarts only after a compare
*/

`timescale 1ns/100ps

module csi2_payload_crc
  import csi2_pkt_pkg::*;
(
  input                 rx_clk,
  input                 clk_loss_rst,
  input  csi2_word_t    pkt_i,
  input        [15 : 0] rx_crc_i,
  input                 rx_crc_valid_i,
  output logic          crc_ok_o,
  output logic          crc_bad_o
);

logic [15 : 0] crc;
logic [15 : 0] crc_next;

// One byte through the reflected polynomial, LSB first
function automatic logic [15 : 0] crc_byte( input logic [15 : 0] crc_in,
                                            input logic [7 : 0]  data );
  logic [15 : 0] c;
  c = crc_in ^ { 8'h00, data };
  for( int i = 0; i < 8; i++ )
    c = c[0] ? ( c >> 1 ) ^ CSI2_CRC_POLY : c >> 1;
  return c;
endfunction

// Includes the current word, the CRC may share it
always_comb
  begin
    crc_next = crc;
    if( pkt_i.tvalid )
      for( int b = 0; b < 4; b++ )
        if( pkt_i.tstrb[b] )
          crc_next = crc_byte( crc_next, pkt_i.tdata[8 * b +: 8] );
  end

always_ff @( posedge rx_clk, posedge clk_loss_rst )
  if( clk_loss_rst )
    begin
      crc       <= CSI2_CRC_INIT;
      crc_ok_o  <= 1'b0;
      crc_bad_o <= 1'b0;
    end
  else
    begin
      crc_ok_o  <= rx_crc_valid_i && ( rx_crc_i == crc_next );
      crc_bad_o <= rx_crc_valid_i && ( rx_crc_i != crc_next );
      crc       <= rx_crc_valid_i ? CSI2_CRC_INIT : crc_next;
    end

endmodule

// File: hdl/csi2_rx_status.sv
/*
  Registered error pulses and saturating error counters
  Header flags get an extra stage to line up with the framer outputs
*/

`timescale 1ns/100ps

module csi2_rx_status
  import csi2_status_pkg::*;
#(
  parameter int ERR_CNT_WIDTH = 8
)(
  input                              rx_clk,
  input                              clk_loss_rst,
  input                              hdr_valid_i,
  input                              hdr_err_i,
  input                              hdr_corr_i,
  input                              crc_ok_i,
  input                              crc_bad_i,
  output csi2_err_t                  status_o,
  output logic [ERR_CNT_WIDTH - 1 : 0] hdr_err_cnt_o,
  output logic [ERR_CNT_WIDTH - 1 : 0] crc_err_cnt_o
);

logic      hdr_err_q;
logic      hdr_corr_q;
csi2_err_t err_n;

function automatic logic [ERR_CNT_WIDTH - 1 : 0] sat_inc(
  input logic [ERR_CNT_WIDTH - 1 : 0] cnt,
  input logic                         inc
);
  return ( inc && ( cnt != '1 ) ) ? cnt + 1'b1 : cnt;
endfunction

assign err_n = '{ header_err: hdr_err_q, header_corr: hdr_corr_q,
                  crc_err: crc_bad_i, crc_ok: crc_ok_i };

always_ff @( posedge rx_clk, posedge clk_loss_rst )
  if( clk_loss_rst )
    begin
      hdr_err_q     <= 1'b0;
      hdr_corr_q    <= 1'b0;
      status_o      <= '0;
      hdr_err_cnt_o <= '0;
      crc_err_cnt_o <= '0;
    end
  else
    begin
      hdr_err_q     <= hdr_valid_i && hdr_err_i;
      hdr_corr_q    <= hdr_valid_i && hdr_err_i && hdr_corr_i;
      status_o      <= err_n;
      // Only uncorrectable headers count
      hdr_err_cnt_o <= sat_inc( hdr_err_cnt_o, hdr_err_q && !hdr_corr_q );
      crc_err_cnt_o <= sat_inc( crc_err_cnt_o, crc_bad_i );
    end

endmodule

// File: hdl/csi2_rx_core.sv
/*
  rx_clk side of the CSI-2 receiver: header ECC, framing, CRC and status
  Expects aligned 32-bit words from the lane merger; cannot stall the PHY
  pkt_done_o must be fed back to the D-PHY for resync
*/

`timescale 1ns/100ps

module csi2_rx_core
  import csi2_pkt_pkg::*, csi2_status_pkg::*;
#(
  parameter int ERR_CNT_WIDTH = 8
)(
  input                                rx_clk,
  input                                clk_loss_rst,
  input                                enable_i,
  input        [31 : 0]                phy_data_i,
  input                                phy_valid_i,
  output csi2_word_t                   video_o,
  output logic                         frame_start_o,
  output logic                         frame_end_o,
  output logic                         pkt_done_o,
  output csi2_err_t                    status_o,
  output logic [ERR_CNT_WIDTH - 1 : 0] hdr_err_cnt_o,
  output logic [ERR_CNT_WIDTH - 1 : 0] crc_err_cnt_o
);

logic [31 : 0] corr_data;
logic          corr_valid;
logic          hdr_valid;
logic          hdr_err;
logic          hdr_corr;
csi2_word_t    pkt_word;
logic [15 : 0] rx_crc;
logic          rx_crc_valid;
logic          pkt_done;
logic          crc_ok;
logic          crc_bad;

assign video_o    = pkt_word;
assign pkt_done_o = pkt_done;

csi2_header_ecc header_ecc (
  .rx_clk       ( rx_clk       ),
  .clk_loss_rst ( clk_loss_rst ),
  .phy_data_i   ( phy_data_i   ),
  .phy_valid_i  ( phy_valid_i  ),
  .pkt_done_i   ( pkt_done     ),
  .data_o       ( corr_data    ),
  .valid_o      ( corr_valid   ),
  .hdr_valid_o  ( hdr_valid    ),
  .hdr_err_o    ( hdr_err      ),
  .hdr_corr_o   ( hdr_corr     )
);

// Also drives the PHY resync pulse
csi2_pkt_framer pkt_framer (
  .rx_clk         ( rx_clk        ),
  .clk_loss_rst   ( clk_loss_rst  ),
  .enable_i       ( enable_i      ),
  .data_i         ( corr_data     ),
  .valid_i        ( corr_valid    ),
  .hdr_valid_i    ( hdr_valid     ),
  .hdr_err_i      ( hdr_err       ),
  .hdr_corr_i     ( hdr_corr      ),
  .pkt_o          ( pkt_word      ),
  .rx_crc_o       ( rx_crc        ),
  .rx_crc_valid_o ( rx_crc_valid  ),
  .frame_start_o  ( frame_start_o ),
  .frame_end_o    ( frame_end_o   ),
  .pkt_done_o     ( pkt_done      )
);

csi2_payload_crc payload_crc (
  .rx_clk         ( rx_clk       ),
  .clk_loss_rst   ( clk_loss_rst ),
  .pkt_i          ( pkt_word     ),
  .rx_crc_i       ( rx_crc       ),
  .rx_crc_valid_i ( rx_crc_valid ),
  .crc_ok_o       ( crc_ok       ),
  .crc_bad_o      ( crc_bad      )
);

csi2_rx_status #(
  .ERR_CNT_WIDTH ( ERR_CNT_WIDTH )
) rx_status (
  .rx_clk        ( rx_clk        ),
  .clk_loss_rst  ( clk_loss_rst  ),
  .hdr_valid_i   ( hdr_valid     ),
  .hdr_err_i     ( hdr_err       ),
  .hdr_corr_i    ( hdr_corr      ),
  .crc_ok_i      ( crc_ok        ),
  .crc_bad_i     ( crc_bad       ),
  .status_o      ( status_o      ),
  .hdr_err_cnt_o ( hdr_err_cnt_o ),
  .crc_err_cnt_o ( crc_err_cnt_o )
);

endmodule

// File: verif/csi2_tb_model.svh
/*
  Reference model for the CSI-2 testbench, included inside the testbench module
  Packet words collect in pkt_words; payload bytes go LSB first, CRC low byte first
*/

`ifndef CSI2_TB_MODEL_SVH
`define CSI2_TB_MODEL_SVH

typedef logic [7 : 0] byte_q_t[$];

// Words of the packet being built, header first
logic [31 : 0] pkt_words[$];

// Parity bit i covers the header bits set in mask i, D0 is DI bit 0
function automatic logic [7 : 0] ecc_of_header( input logic [23 : 0] d );
  logic [23 : 0] mask [6];
  logic [7 : 0]  ecc;
  mask = '{ 24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00 };
  ecc  = '0;
  for( int i = 0; i < 6; i++ )
    ecc[i] = ^( d & mask[i] );
  return ecc;
endfunction

// Bit-serial CRC-16, reflected 0x8408, start value all ones
function automatic logic [15 : 0] crc_of_bytes( input byte_q_t bytes );
  logic [15 : 0] crc;
  logic          fb;
  crc = 16'hFFFF;
  foreach( bytes[k] )
    for( int i = 0; i < 8; i++ )
      begin
        fb  = crc[0] ^ bytes[k][i];
        crc = crc >> 1;
        if( fb )
          crc = crc ^ 16'h8408;
      end
  return crc;
endfunction

function automatic void short_packet( input logic [7 : 0] di, input logic [15 : 0] wc );
  pkt_words.delete();
  pkt_words.push_back( { ecc_of_header( { wc, di } ), wc, di } );
endfunction

// crc_xor corrupts the transmitted CRC, zero keeps it intact
function automatic void long_packet( input logic [7 : 0] di, input byte_q_t pay,
                                     input logic [15 : 0] crc_xor );
  byte_q_t       bytes;
  logic [15 : 0] crc;
  logic [31 : 0] w;
  crc   = crc_of_bytes( pay ) ^ crc_xor;
  bytes = pay;
  bytes.push_back( crc[7 : 0] );
  bytes.push_back( crc[15 : 8] );
  short_packet( di, 16'( pay.size() ) );
  w = '0;
  foreach( bytes[k] )
    begin
      w[8 * ( k % 4 ) +: 8] = bytes[k];
      if( ( k % 4 == 3 ) || ( k == bytes.size() - 1 ) )
        begin
          pkt_words.push_back( w );
          w = '0;
        end
    end
endfunction

`endif

// File: verif/tb_csi2_rx.sv
/*
  Directed testbench for the CSI-2 rx_clk core with 4-bit error counters
  Packets are separated by idle cycles so the resync pulse lands between them
*/

`timescale 1ns/100ps

module tb_csi2_rx
  import csi2_pkt_pkg::*, csi2_status_pkg::*;
();

logic          rx_clk;
logic          clk_loss_rst;
logic          enable;
logic [31 : 0] phy_data;
logic          phy_valid;
csi2_word_t    video;
logic          frame_start;
logic          frame_end;
logic          pkt_done;
csi2_err_t     status;
logic [3 : 0]  hdr_err_cnt;
logic [3 : 0]  crc_err_cnt;

int err_cnt     = 0;
int timeout_cnt = 0;

`include "csi2_tb_model.svh"

byte_q_t payload;

// Output activity seen since the last clear
logic [7 : 0] rx_bytes[$];
int last_pos;
int n_last;
int n_video;
int n_done;
int n_fs;
int n_fe;
int n_crc_ok;
int n_crc_err;
int n_hdr_err;
int n_hdr_corr;

csi2_rx_core #(
  .ERR_CNT_WIDTH ( 4 )
) i_dut (
  .rx_clk        ( rx_clk       ),
  .clk_loss_rst  ( clk_loss_rst ),
  .enable_i      ( enable       ),
  .phy_data_i    ( phy_data     ),
  .phy_valid_i   ( phy_valid    ),
  .video_o       ( video        ),
  .frame_start_o ( frame_start  ),
  .frame_end_o   ( frame_end    ),
  .pkt_done_o    ( pkt_done     ),
  .status_o      ( status       ),
  .hdr_err_cnt_o ( hdr_err_cnt  ),
  .crc_err_cnt_o ( crc_err_cnt  )
);

initial
  begin
    rx_clk = 1'b0;
    forever
      #2 rx_clk = !rx_clk;
  end

// Outputs are sampled mid-cycle
always @( negedge rx_clk )
  if( !clk_loss_rst )
    begin
      if( video.tvalid )
        begin
          n_video++;
          for( int b = 0; b < 4; b++ )
            if( video.tstrb[b] )
              rx_bytes.push_back( video.tdata[8 * b +: 8] );
          if( video.tlast )
            begin
              n_last++;
              last_pos = rx_bytes.size();
            end
        end
      n_done     = n_done + int'( pkt_done );
      n_fs       = n_fs + int'( frame_start );
      n_fe       = n_fe + int'( frame_end );
      n_crc_ok   = n_crc_ok + int'( status.crc_ok );
      n_crc_err  = n_crc_err + int'( status.crc_err );
      n_hdr_err  = n_hdr_err + int'( status.header_err );
      n_hdr_corr = n_hdr_corr + int'( status.header_corr );
    end

task automatic clear_monitor;
  rx_bytes.delete();
  last_pos   = -1;
  n_last     = 0;
  n_video    = 0;
  n_done     = 0;
  n_fs       = 0;
  n_fe       = 0;
  n_crc_ok   = 0;
  n_crc_err  = 0;
  n_hdr_err  = 0;
  n_hdr_corr = 0;
endtask

task automatic compare_count( input string what, input int got, input int exp );
  if( got != exp )
    begin
      $display( "MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp );
      err_cnt++;
    end
endtask

function automatic void make_payload( input int n );
  payload.delete();
  repeat( n )
    payload.push_back( 8'( $urandom ) );
endfunction

task automatic prepare_long( input logic [31 : 0] hdr_flip, input logic [15 : 0] crc_xor );
  make_payload( $urandom_range( 17, 1 ) );
  // RAW10 on virtual channel 0
  long_packet( 8'h2B, payload, crc_xor );
  pkt_words[0] = pkt_words[0] ^ hdr_flip;
endtask

task automatic send_words( input bit gaps );
  foreach( pkt_words[i] )
    begin
      if( gaps )
        repeat( $urandom_range( 2 ) )
          begin
            phy_valid <= 1'b0;
            @( posedge rx_clk );
          end
      phy_data  <= pkt_words[i];
      phy_valid <= 1'b1;
      @( posedge rx_clk );
    end
  phy_valid <= 1'b0;
  phy_data  <= '0;
endtask

task automatic wait_done;
  int cyc;
  cyc = 0;
  while( ( n_done == 0 ) && ( cyc < 200 ) )
    begin
      @( posedge rx_clk );
      cyc++;
    end
  if( n_done == 0 )
    begin
      $display( "ERROR at %0t ns: no pkt_done pulse within 200 cycles", $time );
      timeout_cnt++;
    end
  // CRC status and counters trail pkt_done by up to two cycles
  repeat( 4 )
    @( posedge rx_clk );
endtask

task automatic run_packet( input bit gaps );
  clear_monitor();
  send_words( gaps );
  wait_done();
endtask

task automatic check_payload;
  compare_count( "payload byte count", rx_bytes.size(), payload.size() );
  foreach( payload[i] )
    if( ( i < rx_bytes.size() ) && ( rx_bytes[i] != payload[i] ) )
      begin
        $display( "MISMATCH at %0t ns: payload byte %0d is %h, expected %h",
                  $time, i, rx_bytes[i], payload[i] );
        err_cnt++;
      end
  compare_count( "tlast count", n_last, 1 );
  compare_count( "tlast byte position", last_pos, payload.size() );
endtask

task automatic clean_packet;
  prepare_long( '0, '0 );
  run_packet( 0 );
  check_payload();
  compare_count( "crc_ok pulses", n_crc_ok, 1 );
  compare_count( "crc_err pulses", n_crc_err, 0 );
  compare_count( "pkt_done pulses", n_done, 1 );
endtask

task automatic corrected_header;
  int cnt_before;
  repeat( 4 )
    begin
      cnt_before = hdr_err_cnt;
      // Flips stay in bits 29:0 as ECC bits 7:6 are reserved
      prepare_long( 32'd1 << $urandom_range( 29 ), '0 );
      run_packet( 0 );
      check_payload();
      compare_count( "header_err pulses", n_hdr_err, 1 );
      compare_count( "header_corr pulses", n_hdr_corr, 1 );
      compare_count( "crc_ok pulses", n_crc_ok, 1 );
      compare_count( "header error counter", hdr_err_cnt, cnt_before );
    end
endtask

task automatic bad_header;
  int cnt_before;
  int a;
  int b;
  cnt_before = hdr_err_cnt;
  a          = $urandom_range( 29 );
  b          = ( a + $urandom_range( 29, 1 ) ) % 30;
  prepare_long( ( 32'd1 << a ) | ( 32'd1 << b ), '0 );
  // Only the header and the word behind it reach the core before the PHY resyncs
  while( pkt_words.size() > 2 )
    void'( pkt_words.pop_back() );
  run_packet( 0 );
  compare_count( "video words after bad header", n_video, 0 );
  compare_count( "header_err pulses", n_hdr_err, 1 );
  compare_count( "header_corr pulses", n_hdr_corr, 0 );
  compare_count( "pkt_done pulses", n_done, 1 );
  compare_count( "header error counter", hdr_err_cnt, cnt_before + 1 );
  clean_packet();
endtask

task automatic crc_errors;
  int            exp_cnt;
  logic [15 : 0] crc_xor;
  exp_cnt = crc_err_cnt;
  repeat( 20 )
    begin
      crc_xor = { 8'h00, 8'( $urandom_range( 255, 1 ) ) };
      if( $urandom_range( 1 ) )
        crc_xor = { crc_xor[7 : 0], 8'h00 };
      prepare_long( '0, crc_xor );
      run_packet( 0 );
      check_payload();
      compare_count( "crc_err pulses", n_crc_err, 1 );
      compare_count( "crc_ok pulses", n_crc_ok, 0 );
      if( exp_cnt < 15 )
        exp_cnt++;
      compare_count( "CRC error counter", crc_err_cnt, exp_cnt );
    end
  compare_count( "saturated CRC error counter", crc_err_cnt, 15 );
endtask

task automatic frame_packets;
  // Frame Start is data type 0x00 and Frame End is 0x01
  short_packet( 8'h00, 16'( $urandom_range( 65535 ) ) );
  run_packet( 0 );
  compare_count( "frame_start pulses on FS", n_fs, 1 );
  compare_count( "frame_end pulses on FS", n_fe, 0 );
  compare_count( "video words on FS", n_video, 0 );
  compare_count( "pkt_done pulses on FS", n_done, 1 );
  short_packet( 8'h01, 16'( $urandom_range( 65535 ) ) );
  run_packet( 0 );
  compare_count( "frame_start pulses on FE", n_fs, 0 );
  compare_count( "frame_end pulses on FE", n_fe, 1 );
  compare_count( "video words on FE", n_video, 0 );
  compare_count( "pkt_done pulses on FE", n_done, 1 );
endtask

task automatic gaps_and_disable;
  repeat( 4 )
    begin
      prepare_long( '0, '0 );
      run_packet( 1 );
      check_payload();
      compare_count( "crc_ok pulses with gaps", n_crc_ok, 1 );
    end
  enable <= 1'b0;
  prepare_long( '0, '0 );
  clear_monitor();
  send_words( 1 );
  // A Frame Start header is dropped as well
  short_packet( 8'h00, 16'h0000 );
  send_words( 1 );
  repeat( 6 )
    @( posedge rx_clk );
  compare_count( "video words while disabled", n_video, 0 );
  compare_count( "frame pulses while disabled", n_fs + n_fe, 0 );
  compare_count( "crc_ok pulses while disabled", n_crc_ok, 0 );
  enable <= 1'b1;
  repeat( 3 )
    @( posedge rx_clk );
  clean_packet();
endtask

initial
  begin
    void'( $urandom( 32'h3afd ) );
    clk_loss_rst = 1'b1;
    enable       = 1'b1;
    phy_data     = '0;
    phy_valid    = 1'b0;
    clear_monitor();
    repeat( 2 )
      @( posedge rx_clk );
    clk_loss_rst <= 1'b0;
    repeat( 2 )
      @( posedge rx_clk );
    compare_count( "output pulses after reset", n_video + n_done + n_fs + n_fe, 0 );
    compare_count( "status pulses after reset",
                   n_crc_ok + n_crc_err + n_hdr_err + n_hdr_corr, 0 );
    compare_count( "error counters after reset", hdr_err_cnt + crc_err_cnt, 0 );
    clean_packet();
    corrected_header();
    bad_header();
    crc_errors();
    frame_packets();
    gaps_and_disable();
    $display( "Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt );
    if( ( err_cnt == 0 ) && ( timeout_cnt == 0 ) )
      $display( "Simulation PASSED" );
    else
      $display( "Simulation FAILED" );
    $finish;
  end

endmodule

// File: project.f
+incdir+verif
hdl/csi2_pkt_pkg.sv
hdl/csi2_status_pkg.sv
hdl/csi2_header_ecc.sv
hdl/csi2_pkt_framer.sv
hdl/csi2_payload_crc.sv
hdl/csi2_rx_status.sv
hdl/csi2_rx_core.sv
verif/tb_csi2_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSI-2 receiver testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_csi2_rx -f project.f \
  -Mdir obj_dir -o tb_csi2_rx || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_csi2_rx > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
